// ==== include/hdmi_defs.svh ====
/*
 * DVI transmitter constants
 * Channel count and word widths fixed by the DVI link
 */
`ifndef HDMI_DEFS_SVH
`define HDMI_DEFS_SVH

// Colour channels: blue, green, red
`define TMDS_CHANNELS 3

// One encoded TMDS symbol
`define TMDS_WORD_W 10

// Colour component after widening
`define TMDS_DATA_W 8

`define VGA_COLOR_W 4 // RGB444 from the SoC

`endif

// ==== rtl/tmds_pkg.sv ====
/*
 * TMDS types
 * Period selector and symbol type shared by the transmitter
 */
`include "hdmi_defs.svh"

package tmds_pkg;

    // Which encoding an encoder applies this pixel
    typedef enum logic {
        PERIOD_CONTROL = 1'b0, // Sync codes, blank high
        PERIOD_VIDEO   = 1'b1  // 8b/10b pixel data
    } tmds_period_e;

    // Serialized LSB first
    typedef logic [`TMDS_WORD_W-1:0] tmds_word_t;

endpackage

// ==== rtl/video_expand.sv ====
/*
 * VGA pixel expander
 * Samples RGB444 with sync and blank at each pixel strobe, widens to RGB888
 * and splits it into per-channel data and control for the TMDS encoders
 */
`include "hdmi_defs.svh"

module video_expand (
    input  logic                                        clk_shift,
    input  logic                                        rst_n_i,
    input  logic                                        pixel_stb_i,
    input  logic [`VGA_COLOR_W-1:0]                     vga_r_i,
    input  logic [`VGA_COLOR_W-1:0]                     vga_g_i,
    input  logic [`VGA_COLOR_W-1:0]                     vga_b_i,
    input  logic                                        vga_hsync_i,
    input  logic                                        vga_vsync_i,
    input  logic                                        vga_blank_i,
    output logic [`TMDS_CHANNELS-1:0][`TMDS_DATA_W-1:0] chan_data_o,
    output logic [`TMDS_CHANNELS-1:0][1:0]              chan_ctrl_o,
    output tmds_pkg::tmds_period_e                      period_o,
    output logic                                        valid_o
);
    import tmds_pkg::*;

    localparam int REP = `TMDS_DATA_W / `VGA_COLOR_W; // Nibble copies per component

    // DVI channel order
    localparam int CH_BLUE  = 0;
    localparam int CH_GREEN = 1;
    localparam int CH_RED   = 2;

    logic [`VGA_COLOR_W-1:0] pix_r, pix_g, pix_b;
    logic                    pix_hsync, pix_vsync, pix_blank;

    // Pixel held for a whole symbol period
    always_ff @(posedge clk_shift) begin
        if (pixel_stb_i) begin
            pix_r     <= vga_r_i;
            pix_g     <= vga_g_i;
            pix_b     <= vga_b_i;
            pix_hsync <= vga_hsync_i;
            pix_vsync <= vga_vsync_i;
            pix_blank <= vga_blank_i;
        end
    end

    always_ff @(posedge clk_shift) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= pixel_stb_i; // One cycle behind the strobe
        end
    end

    always_comb begin
        // 0xA becomes 0xAA, so full scale stays full scale
        chan_data_o[CH_BLUE]  = {REP{pix_b}};
        chan_data_o[CH_GREEN] = {REP{pix_g}};
        chan_data_o[CH_RED]   = {REP{pix_r}};

        chan_ctrl_o[CH_BLUE]  = {pix_vsync, pix_hsync}; // Sync rides on blue only
        chan_ctrl_o[CH_GREEN] = 2'b00;
        chan_ctrl_o[CH_RED]   = 2'b00;

        period_o = pix_blank ? PERIOD_CONTROL : PERIOD_VIDEO;
    end

endmodule

// ==== rtl/tmds_encoder.sv ====
/*
 * TMDS encoder, one channel
 * 8b/10b with transition minimisation and DC balance during video,
 * fixed control codes with disparity cleared while blanked
 */
`include "hdmi_defs.svh"

module tmds_encoder (
    input  logic                    clk_shift,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  tmds_pkg::tmds_period_e  period_i,
    input  logic [`TMDS_DATA_W-1:0] data_i,
    input  logic [1:0]              ctrl_i,
    output tmds_pkg::tmds_word_t    word_o
);
    import tmds_pkg::*;

    // Control period codes, indexed by {c1, c0}
    localparam tmds_word_t CTRL_00 = 10'b1101010100;
    localparam tmds_word_t CTRL_01 = 10'b0010101011;
    localparam tmds_word_t CTRL_10 = 10'b0101010100;
    localparam tmds_word_t CTRL_11 = 10'b1010101011;

    logic [3:0]              n1_data;  // Ones in the input byte
    logic                    use_xnor;
    logic [`TMDS_DATA_W:0]   q_m;      // Minimised byte, bit 8 marks XOR
    logic [3:0]              n1_qm;
    logic signed [5:0]       diff_qm;  // Ones minus zeros of q_m[7:0]
    logic signed [5:0]       two_qm8;
    logic signed [5:0]       two_nqm8;
    logic signed [5:0]       disp;     // Running disparity
    logic signed [5:0]       disp_next;
    tmds_word_t              word_next;
    tmds_word_t              ctrl_code;

    // Stage 1, pick the chaining with fewer transitions
    always_comb begin
        n1_data  = 4'($countones(data_i));
        use_xnor = (n1_data > 4'd4) || (n1_data == 4'd4 && !data_i[0]);
        q_m[0]   = data_i[0];
        for (int i = 1; i < `TMDS_DATA_W; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_i[i]) : (q_m[i-1] ^ data_i[i]);
        end
        q_m[`TMDS_DATA_W] = ~use_xnor;
    end

    // Stage 2, DC balance against the running disparity
    always_comb begin
        n1_qm    = 4'($countones(q_m[`TMDS_DATA_W-1:0]));
        diff_qm  = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8; // 2*n1 - 8
        two_qm8  = q_m[8] ? 6'sd2 : 6'sd0;
        two_nqm8 = q_m[8] ? 6'sd0 : 6'sd2;

        if (disp == 6'sd0 || diff_qm == 6'sd0) begin
            // Balanced byte or no history, invert only XNOR words
            word_next = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp + diff_qm : disp - diff_qm;
        end else if ((disp > 6'sd0 && diff_qm > 6'sd0) ||
                     (disp < 6'sd0 && diff_qm < 6'sd0)) begin
            word_next = {1'b1, q_m[8], ~q_m[7:0]}; // Excess agrees with disparity, flip
            disp_next = disp + two_qm8 - diff_qm;
        end else begin
            word_next = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp - two_nqm8 + diff_qm;
        end
    end

    always_comb begin
        case (ctrl_i)
            2'b00:   ctrl_code = CTRL_00;
            2'b01:   ctrl_code = CTRL_01;
            2'b10:   ctrl_code = CTRL_10;
            default: ctrl_code = CTRL_11;
        endcase
    end

    // Word and disparity move only on valid
    always_ff @(posedge clk_shift) begin
        if (!rst_n_i) begin
            word_o <= '0;
            disp   <= '0;
        end else if (valid_i) begin
            if (period_i == PERIOD_VIDEO) begin
                word_o <= word_next;
                disp   <= disp_next;
            end else begin
                word_o <= ctrl_code;
                disp   <= '0; // Blanking restarts the balance
            end
        end
    end

endmodule

// ==== rtl/tmds_serializer.sv ====
/*
 * TMDS serializer
 * Mod-10 symbol counter with pixel strobe, shifts three data lanes
 * and the clock lane out LSB first, one bit per shift clock
 */
`include "hdmi_defs.svh"

module tmds_serializer (
    input  logic                                      clk_shift,
    input  logic                                      rst_n_i,
    input  tmds_pkg::tmds_word_t [`TMDS_CHANNELS-1:0] chan_word_i,
    output logic                                      pixel_stb_o,
    output logic [`TMDS_CHANNELS:0]                   gpdi_dp_o
);
    import tmds_pkg::*;

    // Five ones then five zeros on the wire
    localparam tmds_word_t CLK_PATTERN = 10'b0000011111;
    localparam logic [3:0] CNT_LAST    = 4'(`TMDS_WORD_W - 1);

    logic [3:0]                      sym_cnt; // Bit position within the symbol
    tmds_word_t [`TMDS_CHANNELS-1:0] data_sr;
    tmds_word_t                      clk_sr;

    always_ff @(posedge clk_shift) begin
        if (!rst_n_i) begin
            sym_cnt <= '0;
        end else if (pixel_stb_o) begin
            sym_cnt <= '0; // Wrap after bit 9
        end else begin
            sym_cnt <= sym_cnt + 4'd1;
        end
    end

    // Last bit of the symbol, next words go in at this edge
    assign pixel_stb_o = (sym_cnt == CNT_LAST);

    always_ff @(posedge clk_shift) begin
        if (!rst_n_i) begin
            data_sr <= '0;
            clk_sr  <= '0; // Lanes idle low until the first load
        end else if (pixel_stb_o) begin
            data_sr <= chan_word_i;
            clk_sr  <= CLK_PATTERN;
        end else begin
            for (int c = 0; c < `TMDS_CHANNELS; c++) begin
                data_sr[c] <= data_sr[c] >> 1;
            end
            clk_sr <= clk_sr >> 1;
        end
    end

    // Lane 0 blue, 1 green, 2 red, 3 clock
    always_comb begin
        for (int c = 0; c < `TMDS_CHANNELS; c++) begin
            gpdi_dp_o[c] = data_sr[c][0];
        end
        gpdi_dp_o[`TMDS_CHANNELS] = clk_sr[0];
    end

endmodule

// ==== rtl/hdmi_tx.sv ====
/*
 * DVI transmitter top
 * VGA expander, three TMDS encoders and the lane serializer on clk_shift
 */
`include "hdmi_defs.svh"

module hdmi_tx (
    input  logic                    clk_shift,   // 10x pixel rate
    input  logic                    rst_n_i,
    input  logic [`VGA_COLOR_W-1:0] vga_r_i,
    input  logic [`VGA_COLOR_W-1:0] vga_g_i,
    input  logic [`VGA_COLOR_W-1:0] vga_b_i,
    input  logic                    vga_hsync_i,
    input  logic                    vga_vsync_i,
    input  logic                    vga_blank_i,
    output logic                    pixel_stb_o, // Source steps to the next pixel
    output logic [`TMDS_CHANNELS:0] gpdi_dp_o
);
    import tmds_pkg::*;

    logic [`TMDS_CHANNELS-1:0][`TMDS_DATA_W-1:0] chan_data;
    logic [`TMDS_CHANNELS-1:0][1:0]              chan_ctrl;
    tmds_period_e                                period;
    logic                                        chan_valid;
    tmds_word_t [`TMDS_CHANNELS-1:0]             chan_word;

    // Pixel capture and RGB444 to RGB888
    video_expand video_expand_inst (
        .clk_shift   (clk_shift),
        .rst_n_i     (rst_n_i),
        .pixel_stb_i (pixel_stb_o),
        .vga_r_i     (vga_r_i),
        .vga_g_i     (vga_g_i),
        .vga_b_i     (vga_b_i),
        .vga_hsync_i (vga_hsync_i),
        .vga_vsync_i (vga_vsync_i),
        .vga_blank_i (vga_blank_i),
        .chan_data_o (chan_data),
        .chan_ctrl_o (chan_ctrl),
        .period_o    (period),
        .valid_o     (chan_valid)
    );

    // One encoder per colour, all sharing period and valid
    for (genvar c = 0; c < `TMDS_CHANNELS; c++) begin : g_chan
        tmds_encoder tmds_encoder_inst (
            .clk_shift (clk_shift),
            .rst_n_i   (rst_n_i),
            .valid_i   (chan_valid),
            .period_i  (period),
            .data_i    (chan_data[c]),
            .ctrl_i    (chan_ctrl[c]),
            .word_o    (chan_word[c])
        );
    end

    // Also the pacing source for the whole chain
    tmds_serializer tmds_serializer_inst (
        .clk_shift   (clk_shift),
        .rst_n_i     (rst_n_i),
        .chan_word_i (chan_word),
        .pixel_stb_o (pixel_stb_o),
        .gpdi_dp_o   (gpdi_dp_o)
    );

endmodule

// ==== dv/clk_gen.sv ====
/*
 * Testbench clock and reset
 * 100 ns shift clock, reset held low for three cycles
 */
module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o; // 100 ns period
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o <= 1'b1; // Released on a falling edge like the other inputs
    end

endmodule

// ==== dv/tb_hdmi_tx.sv ====
/*
 * DVI transmitter testbench
 * Random VGA lines in, lane symbols captured and checked against a reference TMDS model
 */
`include "hdmi_defs.svh"

module tb_hdmi_tx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         SYM_CYCLES     = `TMDS_WORD_W;
    localparam int         TEST_PIXELS    = 400;
    localparam int         TIMEOUT_CYCLES = (TEST_PIXELS + 100) * SYM_CYCLES;
    localparam logic [9:0] CLK_SYMBOL     = 10'b0000011111; // Ones go out first

    logic clk_shift, rst_n, pixel_stb;
    logic [`VGA_COLOR_W-1:0] vga_r, vga_g, vga_b;
    logic vga_hsync, vga_vsync, vga_blank;
    logic [`TMDS_CHANNELS:0] gpdi_dp;

    logic [9:0]  lane_sym [`TMDS_CHANNELS+1] = '{default: '0}; // Shift-in per lane
    logic [14:0] pix_q [$];  // {blank, vsync, hsync, r, g, b}
    int          ref_disp [`TMDS_CHANNELS] = '{default: 0};
    logic [15:0] lfsr_state = 16'd16742;
    int gap_cnt, stb_cnt, checked_cnt, cycle_cnt, run_left;
    logic in_blank = 1'b1;
    logic drive_next = 1'b0;

    clk_gen clk_gen_inst (.clk_o(clk_shift), .rst_n_o(rst_n));

    hdmi_tx uut (
        .clk_shift   (clk_shift),
        .rst_n_i     (rst_n),
        .vga_r_i     (vga_r),
        .vga_g_i     (vga_g),
        .vga_b_i     (vga_b),
        .vga_hsync_i (vga_hsync),
        .vga_vsync_i (vga_vsync),
        .vga_blank_i (vga_blank),
        .pixel_stb_o (pixel_stb),
        .gpdi_dp_o   (gpdi_dp)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] got);
        abort_run($sformatf("ERROR %s expected 0x%0h got 0x%0h", sig, exp, got));
    endtask

    // Galois form with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]); // One step per bit
        end
        return v;
    endfunction

    function automatic logic [9:0] control_code(input logic [1:0] c);
        case (c)
            2'b00:   return 10'b1101010100;
            2'b01:   return 10'b0010101011;
            2'b10:   return 10'b0101010100;
            default: return 10'b1010101011;
        endcase
    endfunction

    // Reference DVI 8b/10b keeping its own running disparity per channel
    function automatic logic [9:0] encode_video(input int ch, input logic [7:0] d);
        int         n1;
        int         ones;
        logic       use_xnor;
        logic [8:0] qm;
        logic [9:0] w;
        n1 = 0;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            if (d[i]) n1++;
        end
        use_xnor = (n1 > 4) || (n1 == 4 && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = use_xnor ? ~(qm[i-1] ^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !use_xnor;
        for (int i = 0; i < 8; i++) begin
            if (qm[i]) ones++;
        end
        if (ref_disp[ch] == 0 || ones == 4) begin
            w = {~qm[8], qm[8], qm[8] ? qm[7:0] : ~qm[7:0]};
            ref_disp[ch] += qm[8] ? (2 * ones - 8) : (8 - 2 * ones);
        end else if ((ref_disp[ch] > 0 && ones > 4) || (ref_disp[ch] < 0 && ones < 4)) begin
            w = {1'b1, qm[8], ~qm[7:0]};
            ref_disp[ch] += 2 * int'(qm[8]) + 8 - 2 * ones;
        end else begin
            w = {1'b0, qm[8], qm[7:0]};
            ref_disp[ch] += 2 * ones - 8 - 2 * int'(!qm[8]);
        end
        return w;
    endfunction

    // Undo inversion by bit 9, then the chaining picked by bit 8
    function automatic logic [7:0] decode_symbol(input logic [9:0] w);
        logic [7:0] d;
        logic [7:0] q;
        d = w[9] ? ~w[7:0] : w[7:0];
        q[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
        end
        return q;
    endfunction

    // Active runs of 8..15 pixels, blank runs of 3..10 with random sync
    task automatic next_pixel();
        if (run_left == 0) begin
            in_blank = !in_blank;
            run_left = take_bits(3) + (in_blank ? 3 : 8);
        end
        run_left--;
        vga_blank = in_blank;
        vga_hsync = in_blank ? 1'(take_bits(1)) : 1'b0;
        vga_vsync = in_blank ? 1'(take_bits(1)) : 1'b0;
        vga_r     = 4'(take_bits(4));
        vga_g     = 4'(take_bits(4));
        vga_b     = 4'(take_bits(4));
    endtask

    // Symbol just completed on lanes 0..2 blue green red and lane 3 clock
    task automatic check_symbol_period();
        logic [14:0] pix;
        logic [3:0]  nib [`TMDS_CHANNELS];
        logic [9:0]  exp_sym;
        string       sig;
        if (stb_cnt == 0) begin
            for (int l = 0; l <= `TMDS_CHANNELS; l++) begin
                assert (lane_sym[l] == '0)
                    else report_mismatch($sformatf("gpdi_dp_o[%0d] before load", l), 0,
                                         32'(lane_sym[l]));
            end
        end else begin
            assert (lane_sym[`TMDS_CHANNELS] == CLK_SYMBOL)
                else report_mismatch("gpdi_dp_o[3] clock", 32'(CLK_SYMBOL), 32'(lane_sym[3]));
            if (pix_q.size() < 2) begin
                for (int ch = 0; ch < `TMDS_CHANNELS; ch++) begin
                    assert (lane_sym[ch] == '0) // Encoder words still at reset
                        else report_mismatch($sformatf("gpdi_dp_o[%0d]", ch), 0,
                                             32'(lane_sym[ch]));
                end
            end else begin
                pix = pix_q.pop_front();
                nib[0] = pix[3:0];
                nib[1] = pix[7:4];
                nib[2] = pix[11:8];
                for (int ch = 0; ch < `TMDS_CHANNELS; ch++) begin
                    sig = $sformatf("gpdi_dp_o[%0d] symbol", ch);
                    if (pix[14]) begin
                        exp_sym = control_code(ch == 0 ? pix[13:12] : 2'b00);
                        ref_disp[ch] = 0;
                    end else begin
                        exp_sym = encode_video(ch, {nib[ch], nib[ch]});
                        assert (decode_symbol(lane_sym[ch]) == {nib[ch], nib[ch]})
                            else report_mismatch($sformatf("decoded gpdi_dp_o[%0d]", ch),
                                                 32'({nib[ch], nib[ch]}),
                                                 32'(decode_symbol(lane_sym[ch])));
                    end
                    assert (lane_sym[ch] == exp_sym)
                        else report_mismatch(sig, 32'(exp_sym), 32'(lane_sym[ch]));
                end
                checked_cnt++;
            end
        end
    endtask

    initial begin
        {vga_r, vga_g, vga_b} = '0;
        {vga_hsync, vga_vsync} = 2'b00;
        vga_blank = 1'b1; // First sampled pixel is a control period
    end

    // Idle lanes and no strobe while reset is held
    assert property (@(negedge clk_shift) rst_n || !pixel_stb)
        else report_mismatch("pixel_stb_o during reset", 0, 32'(pixel_stb));
    assert property (@(negedge clk_shift) rst_n || gpdi_dp == '0)
        else report_mismatch("gpdi_dp_o during reset", 0, 32'(gpdi_dp));

    always @(negedge clk_shift) begin
        if (!rst_n) begin
            gap_cnt = 2; // Next falling edge already lies in the second cycle after release
        end else begin
            for (int l = 0; l <= `TMDS_CHANNELS; l++) begin
                lane_sym[l] = {gpdi_dp[l], lane_sym[l][9:1]}; // LSB arrives first
            end
            if (drive_next) begin
                next_pixel();
                drive_next = 1'b0;
            end
            if (pixel_stb || gap_cnt >= SYM_CYCLES) begin
                assert (pixel_stb && gap_cnt == SYM_CYCLES)
                    else report_mismatch("pixel_stb_o period", SYM_CYCLES, gap_cnt);
            end
            gap_cnt++;
            if (pixel_stb) begin
                gap_cnt = 1;
                check_symbol_period();
                pix_q.push_back({vga_blank, vga_vsync, vga_hsync, vga_r, vga_g, vga_b});
                drive_next = 1'b1;
                stb_cnt++;
                if (checked_cnt == TEST_PIXELS) begin
                    $display("Simulation completed successfully");
                    $finish;
                end
            end
        end
    end

    always @(posedge clk_shift) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d pixels checked",
                                cycle_cnt, checked_cnt));
        end
    end

endmodule

// ==== src.f ====
+incdir+include
rtl/tmds_pkg.sv
rtl/video_expand.sv
rtl/tmds_encoder.sv
rtl/tmds_serializer.sv
rtl/hdmi_tx.sv
dv/clk_gen.sv
dv/tb_hdmi_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DVI transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module tb_hdmi_tx \
    -Mdir obj_dir -o sim_hdmi_tx

# Exit status of the pipe is that of tee, the log decides the result
./obj_dir/sim_hdmi_tx 2>&1 | tee "$LOG"

if grep -q "Simulation completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
